//--- common/rt_ctx_params.svh
`ifndef RT_CTX_PARAMS_SVH
`define RT_CTX_PARAMS_SVH

// Thread and queue sizing
`define RT_NUM_THREAD      32
`define RT_THREAD_W        $clog2(`RT_NUM_THREAD)
`define RT_QUEUE_DEPTH     4
`define RT_SLICE_LEN       8
`define RT_RESULT_CREDITS  2

// Register file geometry
`define RT_NUM_SREG        32
`define RT_NUM_VREG        16

// Architectural register indices
`define RT_REG_PID         1
`define RT_REG_SP          29
`define RT_REG_PC          31
`define RT_VREG_ORG        14
`define RT_VREG_DIR        15

`endif

//--- common/rt_ctx_pkg.sv
`default_nettype none

`include "rt_ctx_params.svh"

package rt_ctx_pkg;

    // One vector register, seen whole or as four lanes
    typedef union packed {
        logic [127:0]      raw;
        logic [3:0][31:0]  lane;
    } rt_vec_u;

    typedef struct packed {
        logic [`RT_THREAD_W-1:0] tid;
        logic [31:0]             pid;
        logic [31:0]             pc;
        logic [31:0]             sp;
        rt_vec_u                 org;
        rt_vec_u                 dir;
    } rt_job_t;

    typedef struct packed {
        logic                              sc_we;
        logic [$clog2(`RT_NUM_SREG)-1:0]   sc_addr;
        logic [31:0]                       sc_data;
        logic                              vec_we;
        logic [$clog2(`RT_NUM_VREG)-1:0]   vec_addr;
        rt_vec_u                           vec_data;
    } rt_reg_wr_t;

    typedef struct packed {
        logic [31:0] pid;
        logic [31:0] pc;
        logic [31:0] sp;
        rt_vec_u     org;
        rt_vec_u     dir;
    } rt_ctx_view_t;

    typedef struct packed {
        logic        en;
        logic [31:0] pc;
        logic [31:0] sp;
        rt_vec_u     org;
    } rt_step_t;

    // done is 1 for end of program, 0 for a forced switch
    typedef struct packed {
        logic [`RT_THREAD_W-1:0] tid;
        logic                    done;
        rt_ctx_view_t            ctx;
    } rt_result_t;

endpackage

`default_nettype wire

//--- logic/job_queue.sv
`timescale 1ns/10ps
`default_nettype none

`include "rt_ctx_params.svh"

module job_queue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                job_valid,
    input  rt_ctx_pkg::rt_job_t job,
    output logic                job_credit,
    output logic                head_valid,
    output rt_ctx_pkg::rt_job_t head,
    input  logic                pop
);
    import rt_ctx_pkg::*;

    localparam int PTR_W = $clog2(`RT_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`RT_QUEUE_DEPTH + 1);

    rt_job_t           mem [`RT_QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              full;

    assign full       = count == CNT_W'(`RT_QUEUE_DEPTH);
    assign head_valid = count != '0;
    assign head       = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (job_valid) begin
            mem[wr_ptr] <= job;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            job_credit <= 1'b0;
        end else begin
            // Each pop hands one credit back to the dispatcher
            job_credit <= pop;
            if (job_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(job_valid) - CNT_W'(pop);
        end
    end

    // Dispatcher spent a credit it did not have
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        job_valid |-> !full)
        else $error("job_queue: push into full queue");

endmodule

`default_nettype wire

//--- ctx_loader/ctx_loader.sv
`timescale 1ns/10ps
`default_nettype none

`include "rt_ctx_params.svh"

module ctx_loader (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     head_valid,
    input  rt_ctx_pkg::rt_job_t      head,
    output logic                     pop,
    output logic                     kernel_mode,
    output rt_ctx_pkg::rt_reg_wr_t   reg_wr,
    output logic                     running,
    input  logic                     end_program,
    input  logic                     context_switch,
    input  rt_ctx_pkg::rt_ctx_view_t ctx,
    output logic                     res_valid,
    output rt_ctx_pkg::rt_result_t   res,
    input  logic                     res_ready
);
    import rt_ctx_pkg::*;

    typedef enum logic [2:0] {
        IDLE, LOAD0, LOAD1, LOAD2, LOAD_DONE, RUN, UNLOAD, RESULT
    } state_t;

    state_t   state;
    state_t   state_nxt;
    rt_job_t  job_q;
    logic     done_q;
    logic     run_end;

    assign run_end   = end_program || context_switch;
    assign pop       = (state == IDLE) && head_valid;
    assign running   = state == RUN;
    assign res_valid = state == RESULT;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            done_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (running && run_end) begin
                done_q <= end_program;
            end
        end
    end

    // Job fields and the result record
    always_ff @(posedge clk) begin
        if (pop) begin
            job_q <= head;
        end
        if (state == UNLOAD) begin
            res.tid  <= job_q.tid;
            res.done <= done_q;
            res.ctx  <= ctx;
        end
    end

    always_comb begin
        state_nxt   = state;
        kernel_mode = 1'b1;
        reg_wr      = '0;
        case (state)
            IDLE: begin
                if (head_valid) begin
                    state_nxt = LOAD0;
                end
            end
            LOAD0: begin
                state_nxt       = LOAD1;
                reg_wr.sc_we    = 1'b1;
                reg_wr.sc_addr  = `RT_REG_PID;
                reg_wr.sc_data  = job_q.pid;
                reg_wr.vec_we   = 1'b1;
                reg_wr.vec_addr = `RT_VREG_ORG;
                reg_wr.vec_data = job_q.org;
            end
            LOAD1: begin
                state_nxt       = LOAD2;
                reg_wr.sc_we    = 1'b1;
                reg_wr.sc_addr  = `RT_REG_PC;
                reg_wr.sc_data  = job_q.pc;
                reg_wr.vec_we   = 1'b1;
                reg_wr.vec_addr = `RT_VREG_DIR;
                reg_wr.vec_data = job_q.dir;
            end
            LOAD2: begin
                state_nxt      = LOAD_DONE;
                reg_wr.sc_we   = 1'b1;
                reg_wr.sc_addr = `RT_REG_SP;
                reg_wr.sc_data = job_q.sp;
            end
            LOAD_DONE: state_nxt = RUN;
            RUN: begin
                kernel_mode = 1'b0;
                if (run_end) begin
                    state_nxt = UNLOAD;
                end
            end
            UNLOAD: state_nxt = RESULT;
            default: begin
                // Hold the record until the sender takes it
                if (res_ready) begin
                    state_nxt = IDLE;
                end
            end
        endcase
    end

    a_wr_in_kernel: assert property (@(posedge clk) disable iff (!rst_n)
        (reg_wr.sc_we || reg_wr.vec_we) |-> kernel_mode)
        else $error("ctx_loader: register write outside kernel mode");

    a_run_xor_kernel: assert property (@(posedge clk) disable iff (!rst_n)
        !(running && kernel_mode))
        else $error("ctx_loader: running while in kernel mode");

endmodule

`default_nettype wire

//--- logic/thread_reg_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "rt_ctx_params.svh"

module thread_reg_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  rt_ctx_pkg::rt_reg_wr_t   reg_wr,
    input  rt_ctx_pkg::rt_step_t     step,
    output rt_ctx_pkg::rt_ctx_view_t ctx
);
    import rt_ctx_pkg::*;

    logic [31:0] sreg [`RT_NUM_SREG];
    rt_vec_u     vreg [`RT_NUM_VREG];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RT_NUM_SREG; i++) begin
                sreg[i] <= '0;
            end
            for (int i = 0; i < `RT_NUM_VREG; i++) begin
                vreg[i] <= '0;
            end
        end else if (step.en) begin
            sreg[`RT_REG_PC]       <= step.pc;
            sreg[`RT_REG_SP]       <= step.sp;
            vreg[`RT_VREG_ORG].raw <= step.org.raw;
        end else begin
            if (reg_wr.sc_we) begin
                sreg[reg_wr.sc_addr] <= reg_wr.sc_data;
            end
            if (reg_wr.vec_we) begin
                vreg[reg_wr.vec_addr].raw <= reg_wr.vec_data.raw;
            end
        end
    end

    // Context registers at their fixed indices
    assign ctx.pid     = sreg[`RT_REG_PID];
    assign ctx.pc      = sreg[`RT_REG_PC];
    assign ctx.sp      = sreg[`RT_REG_SP];
    assign ctx.org.raw = vreg[`RT_VREG_ORG].raw;
    assign ctx.dir.raw = vreg[`RT_VREG_DIR].raw;

    a_single_writer: assert property (@(posedge clk) disable iff (!rst_n)
        !(step.en && (reg_wr.sc_we || reg_wr.vec_we)))
        else $error("thread_reg_file: loader and stepper write together");

endmodule

`default_nettype wire

//--- logic/ray_stepper.sv
`timescale 1ns/10ps
`default_nettype none

`include "rt_ctx_params.svh"

module ray_stepper (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     running,
    input  rt_ctx_pkg::rt_ctx_view_t ctx,
    output rt_ctx_pkg::rt_step_t     step,
    output logic                     end_program,
    output logic                     context_switch
);
    import rt_ctx_pkg::*;

    localparam int SLICE_W = $clog2(`RT_SLICE_LEN + 1);

    logic [SLICE_W-1:0] slice_cnt;
    logic               have_steps;
    logic               last_step;
    logic               last_slice;
    rt_vec_u            org_nxt;

    // Stack pointer doubles as the remaining step count
    assign have_steps = ctx.sp != 32'd0;
    assign last_step  = ctx.sp == 32'd1;
    assign last_slice = slice_cnt == SLICE_W'(`RT_SLICE_LEN - 1);

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            org_nxt.lane[i] = ctx.org.lane[i] + ctx.dir.lane[i];
        end
    end

    assign step.en  = running && have_steps;
    assign step.pc  = ctx.pc + 32'd1;
    assign step.sp  = ctx.sp - 32'd1;
    assign step.org = org_nxt;

    assign end_program    = running && (!have_steps || last_step);
    assign context_switch = step.en && last_slice && !last_step;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slice_cnt <= '0;
        end else if (!running) begin
            slice_cnt <= '0;
        end else if (step.en) begin
            slice_cnt <= slice_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/result_sender.sv
`timescale 1ns/10ps
`default_nettype none

`include "rt_ctx_params.svh"

module result_sender (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   res_valid,
    input  rt_ctx_pkg::rt_result_t res,
    output logic                   res_ready,
    output logic                   out_valid,
    output rt_ctx_pkg::rt_result_t out_result,
    input  logic                   result_credit
);
    import rt_ctx_pkg::*;

    localparam int CRD_W = $clog2(`RT_RESULT_CREDITS + 1);

    logic             stage_valid;
    rt_result_t       stage;
    logic [CRD_W-1:0] credits;

    assign res_ready  = !stage_valid;
    assign out_valid  = stage_valid && (credits != '0);
    assign out_result = stage;

    always_ff @(posedge clk) begin
        if (res_valid && res_ready) begin
            stage <= res;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
            credits     <= CRD_W'(`RT_RESULT_CREDITS);
        end else begin
            if (res_valid && res_ready) begin
                stage_valid <= 1'b1;
            end else if (out_valid) begin
                stage_valid <= 1'b0;
            end
            credits <= credits + CRD_W'(result_credit) - CRD_W'(out_valid);
        end
    end

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CRD_W'(`RT_RESULT_CREDITS))
        else $error("result_sender: more credits returned than issued");

endmodule

`default_nettype wire

//--- logic/rt_ctx_top.sv
`timescale 1ns/10ps
`default_nettype none

module rt_ctx_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   job_valid,
    input  rt_ctx_pkg::rt_job_t    job,
    output logic                   job_credit,
    output logic                   out_valid,
    output rt_ctx_pkg::rt_result_t out_result,
    input  logic                   result_credit
);
    import rt_ctx_pkg::*;

    logic         head_valid;
    rt_job_t      head;
    logic         pop;
    logic         kernel_mode;
    rt_reg_wr_t   reg_wr;
    logic         running;
    logic         end_program;
    logic         context_switch;
    rt_ctx_view_t ctx;
    rt_step_t     step;
    logic         res_valid;
    rt_result_t   res;
    logic         res_ready;

    job_queue u_job_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .job_valid  (job_valid),
        .job        (job),
        .job_credit (job_credit),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop)
    );

    ctx_loader u_ctx_loader (
        .clk            (clk),
        .rst_n          (rst_n),
        .head_valid     (head_valid),
        .head           (head),
        .pop            (pop),
        .kernel_mode    (kernel_mode),
        .reg_wr         (reg_wr),
        .running        (running),
        .end_program    (end_program),
        .context_switch (context_switch),
        .ctx            (ctx),
        .res_valid      (res_valid),
        .res            (res),
        .res_ready      (res_ready)
    );

    thread_reg_file u_thread_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .reg_wr (reg_wr),
        .step   (step),
        .ctx    (ctx)
    );

    ray_stepper u_ray_stepper (
        .clk            (clk),
        .rst_n          (rst_n),
        .running        (running),
        .ctx            (ctx),
        .step           (step),
        .end_program    (end_program),
        .context_switch (context_switch)
    );

    result_sender u_result_sender (
        .clk           (clk),
        .rst_n         (rst_n),
        .res_valid     (res_valid),
        .res           (res),
        .res_ready     (res_ready),
        .out_valid     (out_valid),
        .out_result    (out_result),
        .result_credit (result_credit)
    );

endmodule

`default_nettype wire

//--- verif/rt_ctx_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "rt_ctx_params.svh"

module rt_ctx_tb;
    import rt_ctx_pkg::*;

    localparam int N_JOBS          = 27;
    localparam int WATCHDOG_CYCLES = N_JOBS * 40 + 200;
    localparam int T_SHORT = 0;
    localparam int T_LONG  = 1;
    localparam int T_ZERO  = 2;
    localparam int T_BURST = 3;
    localparam int T_HOLD  = 4;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       job_valid;
    rt_job_t    job;
    logic       job_credit;
    logic       out_valid;
    rt_result_t out_result;
    logic       result_credit;

    // Scoreboard and credit bookkeeping
    rt_result_t exp_q[$];
    int         id_q[$];
    rt_result_t exp_head;
    int         exp_id;
    int         exp_cnt = 0;
    int         job_credits = `RT_QUEUE_DEPTH;
    int         dut_credits = `RT_RESULT_CREDITS;
    int         credit_pulses = 0;
    int         jobs_sent = 0;
    int         owed = 0;
    int         hold_extra = 0;
    int         ret_idx = 0;
    int         delay_tab[64];
    logic       started = 1'b0;

    rt_ctx_top u_rt_ctx_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .job_valid     (job_valid),
        .job           (job),
        .job_credit    (job_credit),
        .out_valid     (out_valid),
        .out_result    (out_result),
        .result_credit (result_credit)
    );

    always #50 clk = ~clk;

    function automatic string test_name(int id);
        case (id)
            T_SHORT: return "short_run";
            T_LONG:  return "slice_switch";
            T_ZERO:  return "zero_steps";
            T_BURST: return "queue_burst";
            default: return "withheld_credits";
        endcase
    endfunction

    function automatic rt_result_t expected_result(rt_job_t j);
        rt_result_t  r;
        logic [31:0] n;
        n = (j.sp < 32'(`RT_SLICE_LEN)) ? j.sp : 32'(`RT_SLICE_LEN);
        r.tid     = j.tid;
        r.done    = j.sp <= 32'(`RT_SLICE_LEN);
        r.ctx.pid = j.pid;
        r.ctx.pc  = j.pc + n;
        r.ctx.sp  = j.sp - n;
        // Lanes wrap at 32 bits
        for (int i = 0; i < 4; i++) begin
            r.ctx.org.lane[i] = j.org.lane[i] + n * j.dir.lane[i];
        end
        r.ctx.dir = j.dir;
        return r;
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic mismatch(string test, string exp_s, string act_s);
        fail_run($sformatf("Mismatch in %s: expected %s, actual %s", test, exp_s, act_s));
    endtask

    task automatic refresh_head();
        exp_cnt = exp_q.size();
        if (exp_cnt != 0) begin
            exp_head = exp_q[0];
            exp_id   = id_q[0];
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic send_job(int id, logic [31:0] steps);
        rt_job_t     j;
        logic [31:0] rnd;
        while (job_credits == 0) begin
            @(negedge clk);
        end
        rnd   = $urandom;
        j.tid = rnd[`RT_THREAD_W-1:0];
        j.pid = $urandom;
        j.pc  = $urandom;
        j.sp  = steps;
        for (int i = 0; i < 4; i++) begin
            j.org.lane[i] = $urandom;
            j.dir.lane[i] = $urandom;
        end
        job       = j;
        job_valid = 1'b1;
        started   = 1'b1;
        job_credits--;
        jobs_sent++;
        exp_q.push_back(expected_result(j));
        id_q.push_back(id);
        refresh_head();
        @(negedge clk);
        job_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_cnt != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (job_credit) begin
                job_credits++;
                credit_pulses++;
            end
            dut_credits = dut_credits + int'(result_credit) - int'(out_valid);
            if (out_valid) begin
                owed++;
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                    void'(id_q.pop_front());
                end
                refresh_head();
            end
        end
    end

    // Downstream hands credits back after a table-driven delay
    initial begin
        forever begin
            @(negedge clk);
            result_credit = 1'b0;
            if (owed > 0) begin
                repeat (delay_tab[ret_idx % 64] + hold_extra) @(negedge clk);
                ret_idx++;
                owed--;
                result_credit = 1'b1;
            end
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> (!job_credit && !out_valid))
        else fail_run("job_credit or out_valid rose before any job was sent");

    a_result_expected: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> exp_cnt != 0)
        else fail_run("A result came out with no job outstanding");

    a_result_match: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && exp_cnt != 0) |-> out_result == exp_head)
        else mismatch(test_name($sampled(exp_id)), $sformatf("%h", $sampled(exp_head)),
                      $sformatf("%h", $sampled(out_result)));

    a_out_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> dut_credits != 0)
        else fail_run("out_valid fired while the DUT held no result credit");

    a_job_credit_owed: assert property (@(posedge clk) disable iff (!rst_n)
        job_credit |-> job_credits < `RT_QUEUE_DEPTH)
        else fail_run("job_credit returned a credit that was never spent");

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("Watchdog expired before all results came out");
    end

    initial begin
        void'($urandom(32'h19ac));
        for (int i = 0; i < 64; i++) begin
            delay_tab[i] = $urandom_range(0, 3);
        end
        rst_n         = 1'b0;
        job_valid     = 1'b0;
        job           = '0;
        result_credit = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        // Idle window before any traffic
        repeat (6) @(negedge clk);

        for (int i = 0; i < 6; i++) begin
            send_job(T_SHORT, $urandom_range(1, `RT_SLICE_LEN));
        end
        for (int i = 0; i < 6; i++) begin
            send_job(T_LONG, $urandom_range(`RT_SLICE_LEN + 1, 40));
        end
        for (int i = 0; i < 3; i++) begin
            send_job(T_ZERO, 32'd0);
        end
        wait_drain();

        // All queue credits are home, so these go back to back
        for (int i = 0; i < `RT_QUEUE_DEPTH; i++) begin
            send_job(T_BURST, $urandom_range(0, 20));
        end
        wait_drain();

        hold_extra = 10;
        for (int i = 0; i < 8; i++) begin
            send_job(T_HOLD, $urandom_range(0, 20));
        end
        wait_drain();

        if (credit_pulses != jobs_sent) begin
            mismatch("job_credit_count", $sformatf("%0d", jobs_sent),
                     $sformatf("%0d", credit_pulses));
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+common
common/rt_ctx_pkg.sv
logic/job_queue.sv
ctx_loader/ctx_loader.sv
logic/thread_reg_file.sv
logic/ray_stepper.sv
logic/result_sender.sv
logic/rt_ctx_top.sv
verif/rt_ctx_tb.sv

//--- Bender.yml
package:
  name: rt_ctx

export_include_dirs:
  - common

sources:
  - common/rt_ctx_pkg.sv
  - logic/job_queue.sv
  - ctx_loader/ctx_loader.sv
  - logic/thread_reg_file.sv
  - logic/ray_stepper.sv
  - logic/result_sender.sv
  - logic/rt_ctx_top.sv
  - target: test
    files:
      - verif/rt_ctx_tb.sv
